/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ahb_subsystem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failures found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
common/ahb_pkg.sv
verilog/ahb_decoder.sv
verilog/ahb_slave_mux.sv
ram/ahb_ram.sv
gpio/ahb_gpio.sv
verilog/ahb_subsystem.sv
tb/tb_clock.sv
tb/tb_ahb_subsystem.sv

/* common/ahb_pkg.sv */
package ahb_pkg;

    // Transfer type from the master
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Transfer size, only up to a word on a 32-bit bus
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // Slave response, AHB-Lite has no RETRY or SPLIT
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // GPIO register map, offset from address bits 3:0
    typedef enum logic [3:0] {
        REG_IN  = 4'h0,
        REG_OE  = 4'h4,
        REG_OUT = 4'h8
    } gpio_reg_e;

    // Upper 16 address bits of each mapped region
    localparam logic [15:0] RAMCODE_BASE = 16'h0000;
    localparam logic [15:0] RAMDATA_BASE = 16'h2000;
    localparam logic [15:0] GPIO_BASE    = 16'h4001;

    // NONSEQ or SEQ carries a real transfer
    function automatic logic trans_active(htrans_e trans);
        return (trans == NONSEQ) || (trans == SEQ);
    endfunction

    // Byte lanes touched by a transfer of this size at these low address bits
    function automatic logic [3:0] byte_lanes(hsize_e size, logic [1:0] addr_lo);
        logic [3:0] lanes;
        case (size)
            BYTE:    lanes = 4'b0001 << addr_lo;
            HALF:    lanes = addr_lo[1] ? 4'b1100 : 4'b0011;
            default: lanes = 4'b1111;
        endcase
        return lanes;
    endfunction

endpackage

/* gpio/ahb_gpio.sv */
`timescale 1ns/1ps

module ahb_gpio #(
    parameter int gpio_width = 16
) (
    input  logic                  hclk,
    input  logic                  reset,
    input  logic                  hsel,
    input  logic [31:0]           haddr,
    input  ahb_pkg::htrans_e      htrans,
    input  logic                  hwrite,
    input  ahb_pkg::hsize_e       hsize,
    input  logic [31:0]           hwdata,
    input  logic                  hready_in,
    output logic [31:0]           hrdata,
    output logic                  hreadyout,
    output ahb_pkg::hresp_e       hresp,
    input  logic [gpio_width-1:0] gpio_in,
    output logic [gpio_width-1:0] gpio_out,
    output logic [gpio_width-1:0] gpio_oe
);

    import ahb_pkg::*;

    logic                  accept;
    logic                  wr_pend;
    logic                  rd_wait;
    gpio_reg_e             reg_q;
    hsize_e                size_q;
    logic [1:0]            addr_lo_q;
    logic [3:0]            lanes;
    logic [31:0]           wmask;
    logic [gpio_width-1:0] pin_mask;
    logic [gpio_width-1:0] in_meta;
    logic [gpio_width-1:0] in_sync;
    logic [31:0]           rd_value;
    logic [31:0]           rd_data;

    assign accept = hsel && hready_in && trans_active(htrans);

    // Two-flop synchronizer for the pins
    always_ff @(posedge hclk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    // Read takes one wait cycle, write none
    always_ff @(posedge hclk) begin
        if (reset) begin
            wr_pend <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            if (hready_in) begin
                wr_pend <= accept && hwrite;
            end
            if (rd_wait) begin
                rd_wait <= 1'b0;
            end else if (hready_in) begin
                rd_wait <= accept && !hwrite;
            end
        end
    end

    // Register offset and lane info for the data phase
    always_ff @(posedge hclk) begin
        if (accept) begin
            reg_q     <= gpio_reg_e'(haddr[3:0]);
            size_q    <= hsize;
            addr_lo_q <= haddr[1:0];
        end
    end

    // Narrow writes only touch their own byte lanes
    assign lanes = byte_lanes(size_q, addr_lo_q);
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wmask[8*i +: 8] = {8{lanes[i]}};
        end
    end
    assign pin_mask = wmask[gpio_width-1:0];

    // REG_IN and unknown offsets ignore writes
    always_ff @(posedge hclk) begin
        if (reset) begin
            gpio_oe  <= '0;
            gpio_out <= '0;
        end else if (wr_pend && hready_in) begin
            case (reg_q)
                REG_OE:  gpio_oe  <= (gpio_oe & ~pin_mask) | (hwdata[gpio_width-1:0] & pin_mask);
                REG_OUT: gpio_out <= (gpio_out & ~pin_mask) | (hwdata[gpio_width-1:0] & pin_mask);
                default: ;
            endcase
        end
    end

    // Read value, zero-extended to the bus
    always_comb begin
        rd_value = 32'h0;
        case (reg_q)
            REG_IN:  rd_value[gpio_width-1:0] = in_sync;
            REG_OE:  rd_value[gpio_width-1:0] = gpio_oe;
            REG_OUT: rd_value[gpio_width-1:0] = gpio_out;
            default: rd_value = 32'h0;
        endcase
    end

    // Captured during the wait cycle
    always_ff @(posedge hclk) begin
        if (rd_wait) begin
            rd_data <= rd_value;
        end
    end

    assign hrdata    = rd_data;
    assign hreadyout = !rd_wait;
    assign hresp     = OKAY;

endmodule

/* ram/ahb_ram.sv */
`timescale 1ns/1ps

module ahb_ram #(
    parameter int ram_addr_width = 14
) (
    input  logic             hclk,
    input  logic             reset,
    input  logic             hsel,
    input  logic [31:0]      haddr,
    input  ahb_pkg::htrans_e htrans,
    input  logic             hwrite,
    input  ahb_pkg::hsize_e  hsize,
    input  logic [31:0]      hwdata,
    input  logic             hready_in,
    output logic [31:0]      hrdata,
    output logic             hreadyout,
    output ahb_pkg::hresp_e  hresp
);

    import ahb_pkg::*;

    localparam int depth = 2 ** ram_addr_width;

    // Word-wide storage
    logic [31:0] mem [depth];

    logic                      accept;
    logic                      wr_active;
    logic [ram_addr_width+1:0] addr_q;
    hsize_e                    size_q;
    logic [ram_addr_width-1:0] word_q;
    logic [3:0]                lanes;

    // Address phase aimed at this RAM
    assign accept = hsel && hready_in && trans_active(htrans);

    // Word index and byte lanes of the current data phase
    assign word_q = addr_q[ram_addr_width+1:2];
    assign lanes  = byte_lanes(size_q, addr_q[1:0]);

    // Write flag of the pending data phase
    always_ff @(posedge hclk) begin
        if (reset) begin
            wr_active <= 1'b0;
        end else if (hready_in) begin
            wr_active <= accept && hwrite;
        end
    end

    // Address and size, held through the data phase
    always_ff @(posedge hclk) begin
        if (accept) begin
            addr_q <= haddr[ram_addr_width+1:0];
            size_q <= hsize;
        end
    end

    // Store at the end of the data phase
    // only the lanes the size and low address bits pick
    always_ff @(posedge hclk) begin
        if (wr_active && hready_in) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    mem[word_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // Zero-wait read of the whole word, valid in the data phase
    // a write just before is already in the array here
    assign hrdata = mem[word_q];

    // Never stalls, never errors
    assign hreadyout = 1'b1;
    assign hresp     = OKAY;

endmodule

/* tb/tb_ahb_subsystem.sv */
`timescale 1ns/1ps

module tb_ahb_subsystem;

    import ahb_pkg::*;

    localparam int gpio_width     = 16;
    localparam int ram_addr_width = 14;
    // Longest legal data phase is two cycles
    localparam int timeout_cycles = 20;

    logic                  hclk;
    logic                  reset;
    logic [31:0]           haddr;
    htrans_e               htrans;
    logic                  hwrite;
    hsize_e                hsize;
    logic [31:0]           hwdata;
    logic                  hready_in;
    logic [31:0]           hrdata;
    logic                  hready;
    hresp_e                hresp;
    logic [gpio_width-1:0] gpio_in;
    logic [gpio_width-1:0] gpio_out;
    logic [gpio_width-1:0] gpio_oe;

    integer seed = 32'hc535d31e;
    int     errors;
    int     timeouts;

    // Outcome of the last transfer
    logic [31:0]           last_rdata;
    hresp_e                last_resp;
    hresp_e                first_resp;
    logic                  first_ready;
    int                    last_waits;
    // Last value written to REG_OUT
    logic [gpio_width-1:0] out_model;

    tb_clock #(.period(8)) i_clock (.hclk(hclk));

    ahb_subsystem #(
        .port0_en      (1'b1),
        .port1_en      (1'b1),
        .port2_en      (1'b1),
        .ram_addr_width(ram_addr_width),
        .gpio_width    (gpio_width)
    ) i_dut (
        .hclk, .reset, .haddr, .htrans, .hwrite, .hsize, .hwdata, .hready_in,
        .hrdata, .hready, .hresp, .gpio_in, .gpio_out, .gpio_oe
    );

    // Expected word after a narrow write with lanes picked by size and low address bits
    function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] wdata,
                                                hsize_e size, logic [1:0] lo);
        logic [31:0] result;
        int          b;
        result = old;
        b      = 8 * int'(lo);
        case (size)
            BYTE: result[b +: 8] = wdata[b +: 8];
            HALF: begin
                if (lo[1]) begin
                    result[31:16] = wdata[31:16];
                end else begin
                    result[15:0] = wdata[15:0];
                end
            end
            default: result = wdata;
        endcase
        return result;
    endfunction

    function automatic logic [31:0] zero_extend(logic [31:0] value);
        logic [31:0] result;
        result = '0;
        result[gpio_width-1:0] = value[gpio_width-1:0];
        return result;
    endfunction

    function automatic logic [31:0] gpio_addr(gpio_reg_e offset);
        return {GPIO_BASE, 12'h000, offset};
    endfunction

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input hresp_e got, input hresp_e exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_gpio(input string name, input logic [gpio_width-1:0] got,
                              input logic [gpio_width-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // One single transfer that ends at the falling edge where hready is high
    task automatic bus_transfer(input logic [31:0] addr, input logic write,
                                input hsize_e size, input logic [31:0] wdata);
        bit done;
        int waits;
        done  = 1'b0;
        waits = 0;
        @(posedge hclk);
        haddr  <= addr;
        htrans <= NONSEQ;
        hwrite <= write;
        hsize  <= size;
        // Write data trails the address by one cycle
        @(posedge hclk);
        htrans <= IDLE;
        if (write) begin
            hwdata <= wdata;
        end
        while (!done) begin
            @(negedge hclk);
            if (waits == 0) begin
                first_ready = hready;
                first_resp  = hresp;
            end
            if (hready) begin
                done = 1'b1;
            end else if (waits >= timeout_cycles) begin
                $display("Timeout: hready stayed low for the transfer at %h", addr);
                timeouts++;
                done = 1'b1;
            end else begin
                waits++;
            end
        end
        last_rdata = hrdata;
        last_resp  = hresp;
        last_waits = waits;
    endtask

    task automatic ahb_write(input logic [31:0] addr, input hsize_e size, input logic [31:0] data);
        bus_transfer(addr, 1'b1, size, data);
    endtask

    task automatic ahb_read(input logic [31:0] addr, input hsize_e size, output logic [31:0] data);
        bus_transfer(addr, 1'b0, size, 32'h0);
        data = last_rdata;
    endtask

    // GPIO reads stall for exactly one cycle
    task automatic read_gpio_reg(input gpio_reg_e offset, input logic [31:0] exp);
        logic [31:0] rd;
        ahb_read(gpio_addr(offset), WORD, rd);
        check_data("hrdata GPIO", rd, exp);
        if (last_waits != 1) begin
            $display("GPIO read took %0d wait cycles instead of one", last_waits);
            errors++;
        end
    endtask

    task automatic reset_defaults();
        check_gpio("gpio_oe", gpio_oe, '0);
        check_gpio("gpio_out", gpio_out, '0);
        check_resp("hresp", hresp, OKAY);
        if (!hready) begin
            $display("ERROR hready after reset: got %h, expected %h", hready, 1'b1);
            errors++;
        end
    endtask

    // Same offsets in both RAMs hold different words
    task automatic ram_regions_independent();
        logic [31:0] code_words [4];
        logic [31:0] data_words [4];
        logic [31:0] rd;
        for (int i = 0; i < 4; i++) begin
            code_words[i] = $random(seed);
            data_words[i] = $random(seed);
            ahb_write({RAMCODE_BASE, 16'h0100} + 32'(i * 4), WORD, code_words[i]);
            ahb_write({RAMDATA_BASE, 16'h0100} + 32'(i * 4), WORD, data_words[i]);
        end
        for (int i = 0; i < 4; i++) begin
            ahb_read({RAMCODE_BASE, 16'h0100} + 32'(i * 4), WORD, rd);
            check_data("hrdata code RAM", rd, code_words[i]);
            check_resp("hresp code RAM", last_resp, OKAY);
            ahb_read({RAMDATA_BASE, 16'h0100} + 32'(i * 4), WORD, rd);
            check_data("hrdata data RAM", rd, data_words[i]);
            check_resp("hresp data RAM", last_resp, OKAY);
        end
    endtask

    task automatic narrow_write_lanes();
        logic [31:0] base;
        logic [31:0] expected;
        logic [31:0] wdata;
        logic [31:0] rd;
        base     = {RAMDATA_BASE, 16'h0200};
        expected = $random(seed);
        ahb_write(base, WORD, expected);
        for (int lo = 0; lo < 4; lo++) begin
            wdata = $random(seed);
            ahb_write(base + 32'(lo), BYTE, wdata);
            expected = merge_lanes(expected, wdata, BYTE, 2'(lo));
            ahb_read(base, WORD, rd);
            check_data("hrdata after byte write", rd, expected);
        end
        for (int lo = 0; lo < 4; lo += 2) begin
            wdata = $random(seed);
            ahb_write(base + 32'(lo), HALF, wdata);
            expected = merge_lanes(expected, wdata, HALF, 2'(lo));
            ahb_read(base, WORD, rd);
            check_data("hrdata after halfword write", rd, expected);
        end
    endtask

    task automatic gpio_register_access();
        logic [31:0]           oe_val;
        logic [31:0]           out_val;
        logic [gpio_width-1:0] pins;
        oe_val  = $random(seed);
        out_val = $random(seed);
        pins    = gpio_width'($random(seed));
        ahb_write(gpio_addr(REG_OE), WORD, oe_val);
        ahb_write(gpio_addr(REG_OUT), WORD, out_val);
        out_model = out_val[gpio_width-1:0];
        // Second write lands on the next edge
        @(negedge hclk);
        check_gpio("gpio_oe", gpio_oe, oe_val[gpio_width-1:0]);
        check_gpio("gpio_out", gpio_out, out_val[gpio_width-1:0]);
        read_gpio_reg(REG_OE, zero_extend(oe_val));
        read_gpio_reg(REG_OUT, zero_extend(out_val));
        // Pins need two edges through the synchronizer
        @(posedge hclk);
        gpio_in <= pins;
        repeat (3) @(posedge hclk);
        read_gpio_reg(REG_IN, zero_extend(32'(pins)));
        // Input register is read only
        ahb_write(gpio_addr(REG_IN), WORD, ~32'(pins));
        read_gpio_reg(REG_IN, zero_extend(32'(pins)));
        // Unknown offset drops the write and reads zero
        ahb_write({GPIO_BASE, 16'h000c}, WORD, $random(seed));
        ahb_read({GPIO_BASE, 16'h000c}, WORD, out_val);
        check_data("hrdata GPIO offset 0xc", out_val, 32'h0);
        check_gpio("gpio_oe", gpio_oe, oe_val[gpio_width-1:0]);
    endtask

    task automatic expect_error_response(input logic [31:0] addr, input logic write);
        bus_transfer(addr, write, WORD, 32'h0);
        if (first_ready) begin
            $display("ERROR hready in first error cycle at %h: got %h, expected %h",
                     addr, first_ready, 1'b0);
            errors++;
        end
        check_resp("hresp first error cycle", first_resp, ERROR);
        check_resp("hresp second error cycle", last_resp, ERROR);
    endtask

    task automatic unmapped_regions();
        // Excluded UART and HDMI regions and an unmapped address
        expect_error_response(32'h4000_0010, 1'b0);
        expect_error_response(32'h4002_0000, 1'b0);
        expect_error_response(32'h8000_0000, 1'b0);
        expect_error_response(32'h8000_0000, 1'b1);
    endtask

    task automatic random_ram_traffic();
        logic [31:0] addrs [$];
        logic [31:0] model [logic [31:0]];
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rd;
        int          order [32];
        int          j;
        int          tmp;
        for (int i = 0; i < 32; i++) begin
            addr  = ($random(seed) & 1) ? {RAMDATA_BASE, 16'h0} : {RAMCODE_BASE, 16'h0};
            addr  = addr + (($random(seed) & 32'h3ff) << 2);
            wdata = $random(seed);
            ahb_write(addr, WORD, wdata);
            check_resp("hresp random write", last_resp, OKAY);
            model[addr] = wdata;
            addrs.push_back(addr);
            order[i] = i;
        end
        // Fisher-Yates shuffle of the read order
        for (int i = 31; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 32; i++) begin
            addr = addrs[order[i]];
            ahb_read(addr, WORD, rd);
            check_data("hrdata random read", rd, model[addr]);
            check_resp("hresp random read", last_resp, OKAY);
            if (i % 4 == 3) begin
                read_gpio_reg(REG_OUT, zero_extend(32'(out_model)));
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        haddr     = '0;
        htrans    = IDLE;
        hwrite    = 1'b0;
        hsize     = WORD;
        hwdata    = '0;
        hready_in = 1'b1;
        gpio_in   = '0;
        errors    = 0;
        timeouts  = 0;
        out_model = '0;
        repeat (8) @(posedge hclk);
        reset <= 1'b0;
        @(negedge hclk);
        reset_defaults();
        ram_regions_independent();
        narrow_write_lanes();
        gpio_register_access();
        unmapped_regions();
        random_ram_traffic();
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 8
) (
    output logic hclk
);

    // Free-running bus clock, starts low
    initial begin
        hclk = 1'b0;
        forever begin
            #(period / 2);
            hclk = ~hclk;
        end
    end

endmodule

/* verilog/ahb_decoder.sv */
`timescale 1ns/1ps

module ahb_decoder #(
    // Code RAM port enable
    parameter bit port0_en = 1'b1,
    // Data RAM port enable
    parameter bit port1_en = 1'b1,
    // GPIO port enable
    parameter bit port2_en = 1'b1
) (
    input  logic [31:0] haddr,
    output logic        hsel_ramcode,
    output logic        hsel_ramdata,
    output logic        hsel_gpio
);

    import ahb_pkg::*;

    logic [15:0] region;
    logic        hit_ramcode;
    logic        hit_ramdata;
    logic        hit_gpio;

    // Regions are 64 KB, so only the top half-word matters
    assign region = haddr[31:16];

    // Code RAM, 0x0000_0000 to 0x0000_FFFF
    assign hit_ramcode = (region == RAMCODE_BASE);

    // Data RAM, 0x2000_0000 to 0x2000_FFFF
    assign hit_ramdata = (region == RAMDATA_BASE);

    // GPIO, 0x4001_0000 to 0x4001_FFFF
    assign hit_gpio = (region == GPIO_BASE);

    // A disabled port never selects
    // UART at 0x4000_001x and HDMI at 0x4002_xxxx get no select here
    // and end up at the default slave in the mux
    assign hsel_ramcode = hit_ramcode && port0_en;
    assign hsel_ramdata = hit_ramdata && port1_en;
    assign hsel_gpio    = hit_gpio && port2_en;

endmodule

/* verilog/ahb_slave_mux.sv */
`timescale 1ns/1ps

module ahb_slave_mux (
    input  logic             hclk,
    input  logic             reset,
    input  ahb_pkg::htrans_e htrans,
    input  logic             hready,
    input  logic             hsel_ramcode,
    input  logic             hsel_ramdata,
    input  logic             hsel_gpio,
    input  logic [31:0]      ramcode_hrdata,
    input  logic [31:0]      ramdata_hrdata,
    input  logic [31:0]      gpio_hrdata,
    input  logic             ramcode_hreadyout,
    input  logic             ramdata_hreadyout,
    input  logic             gpio_hreadyout,
    input  ahb_pkg::hresp_e  ramcode_hresp,
    input  ahb_pkg::hresp_e  ramdata_hresp,
    input  ahb_pkg::hresp_e  gpio_hresp,
    output logic [31:0]      hrdata,
    output logic             hready_out,
    output ahb_pkg::hresp_e  hresp
);

    import ahb_pkg::*;

    // Default slave error sequence
    typedef enum logic [1:0] {
        S_IDLE,
        S_ERR1,
        S_ERR2
    } err_state_e;

    err_state_e state;
    err_state_e state_next;
    logic       addr_phase;
    logic       no_sel;
    logic       own_ramcode;
    logic       own_ramdata;
    logic       own_gpio;

    // Accepted address phase
    assign addr_phase = hready && trans_active(htrans);
    // Unmapped or disabled region
    assign no_sel = !(hsel_ramcode || hsel_ramdata || hsel_gpio);

    // Data phase owner, only moves when the bus is ready
    always_ff @(posedge hclk) begin
        if (reset) begin
            own_ramcode <= 1'b0;
            own_ramdata <= 1'b0;
            own_gpio    <= 1'b0;
        end else if (hready) begin
            own_ramcode <= addr_phase && hsel_ramcode;
            own_ramdata <= addr_phase && hsel_ramdata;
            own_gpio    <= addr_phase && hsel_gpio;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ERR1 always goes on, hready is low there
    // IDLE and ERR2 may start a new error on an unmapped access
    always_comb begin
        state_next = state;
        case (state)
            S_ERR1: state_next = S_ERR2;
            default: begin
                if (hready) begin
                    state_next = (addr_phase && no_sel) ? S_ERR1 : S_IDLE;
                end
            end
        endcase
    end

    // Response mux, idle bus answers ready and OKAY
    always_comb begin
        hrdata     = 32'h0;
        hready_out = 1'b1;
        hresp      = OKAY;
        if (state == S_ERR1) begin
            // First error cycle stalls the master
            hready_out = 1'b0;
            hresp      = ERROR;
        end else if (state == S_ERR2) begin
            hresp = ERROR;
        end else if (own_ramcode) begin
            hrdata     = ramcode_hrdata;
            hready_out = ramcode_hreadyout;
            hresp      = ramcode_hresp;
        end else if (own_ramdata) begin
            hrdata     = ramdata_hrdata;
            hready_out = ramdata_hreadyout;
            hresp      = ramdata_hresp;
        end else if (own_gpio) begin
            hrdata     = gpio_hrdata;
            hready_out = gpio_hreadyout;
            hresp      = gpio_hresp;
        end
    end

endmodule

/* verilog/ahb_subsystem.sv */
`timescale 1ns/1ps

module ahb_subsystem #(
    parameter bit port0_en       = 1'b1,
    parameter bit port1_en       = 1'b1,
    parameter bit port2_en       = 1'b1,
    parameter int ram_addr_width = 14,
    parameter int gpio_width     = 16
) (
    input  logic                  hclk,
    input  logic                  reset,
    input  logic [31:0]           haddr,
    input  ahb_pkg::htrans_e      htrans,
    input  logic                  hwrite,
    input  ahb_pkg::hsize_e       hsize,
    input  logic [31:0]           hwdata,
    input  logic                  hready_in,
    output logic [31:0]           hrdata,
    output logic                  hready,
    output ahb_pkg::hresp_e       hresp,
    input  logic [gpio_width-1:0] gpio_in,
    output logic [gpio_width-1:0] gpio_out,
    output logic [gpio_width-1:0] gpio_oe
);

    import ahb_pkg::*;

    logic        hready_bus;
    logic        hsel_ramcode;
    logic        hsel_ramdata;
    logic        hsel_gpio;
    logic [31:0] ramcode_hrdata;
    logic [31:0] ramdata_hrdata;
    logic [31:0] gpio_hrdata;
    logic        ramcode_hreadyout;
    logic        ramdata_hreadyout;
    logic        gpio_hreadyout;
    hresp_e      ramcode_hresp;
    hresp_e      ramdata_hresp;
    hresp_e      gpio_hresp;

    // Bus ready seen by all slaves, master side can also hold it low
    assign hready_bus = hready && hready_in;

    ahb_decoder #(
        .port0_en(port0_en),
        .port1_en(port1_en),
        .port2_en(port2_en)
    ) i_decoder (
        .haddr       (haddr),
        .hsel_ramcode(hsel_ramcode),
        .hsel_ramdata(hsel_ramdata),
        .hsel_gpio   (hsel_gpio)
    );

    ahb_slave_mux i_mux (
        .hclk, .reset, .htrans,
        .hready           (hready_bus),
        .hsel_ramcode, .hsel_ramdata, .hsel_gpio,
        .ramcode_hrdata, .ramdata_hrdata, .gpio_hrdata,
        .ramcode_hreadyout, .ramdata_hreadyout, .gpio_hreadyout,
        .ramcode_hresp, .ramdata_hresp, .gpio_hresp,
        .hrdata, .hresp,
        .hready_out       (hready)
    );

    // Code RAM
    ahb_ram #(.ram_addr_width(ram_addr_width)) i_ramcode (
        .hclk, .reset, .haddr, .htrans, .hwrite, .hsize, .hwdata,
        .hsel     (hsel_ramcode),
        .hready_in(hready_bus),
        .hrdata   (ramcode_hrdata),
        .hreadyout(ramcode_hreadyout),
        .hresp    (ramcode_hresp)
    );

    // Data RAM
    ahb_ram #(.ram_addr_width(ram_addr_width)) i_ramdata (
        .hclk, .reset, .haddr, .htrans, .hwrite, .hsize, .hwdata,
        .hsel     (hsel_ramdata),
        .hready_in(hready_bus),
        .hrdata   (ramdata_hrdata),
        .hreadyout(ramdata_hreadyout),
        .hresp    (ramdata_hresp)
    );

    ahb_gpio #(.gpio_width(gpio_width)) i_gpio (
        .hclk, .reset, .haddr, .htrans, .hwrite, .hsize, .hwdata,
        .hsel     (hsel_gpio),
        .hready_in(hready_bus),
        .hrdata   (gpio_hrdata),
        .hreadyout(gpio_hreadyout),
        .hresp    (gpio_hresp),
        .gpio_in, .gpio_out, .gpio_oe
    );

endmodule
